// ==== exec_pkg.sv ====
package exec_pkg;

    // Operand width of the execution unit
    localparam int data_width = 16;

    typedef logic [data_width-1:0]   word_t;
    typedef logic [2*data_width-1:0] dword_t;
    typedef logic [15:0]             flags_t;

    // Flag bit positions within the flags word
    localparam int cf_idx = 0;
    localparam int pf_idx = 2;
    localparam int zf_idx = 6;
    localparam int sf_idx = 7;
    localparam int of_idx = 11;

    typedef enum logic [3:0] {
        op_add,
        op_adc,
        op_sub,
        op_sbb,
        op_and,
        op_or,
        op_xor,
        op_div,
        op_idiv
    } alu_op_t;

    typedef enum logic [1:0] {
        div_idle,
        div_run,
        div_fix
    } div_state_t;

endpackage

// ==== exec_alu.sv ====
module exec_alu
    import exec_pkg::*;
(
    input  alu_op_t op,
    input  logic    is_8_bit,
    input  word_t   a,
    input  word_t   b,
    input  logic    carry_in,
    output word_t   alu_result,
    output flags_t  alu_flags
);

    word_t               width_mask;
    word_t               a_w;
    word_t               b_w;
    logic                is_sub;
    logic                is_arith;
    logic                cin;
    logic [data_width:0] cin_ext;
    logic [data_width:0] sum;
    word_t               raw;
    logic                sign_a;
    logic                sign_b;
    logic                sign_r;
    logic                carry;
    logic                overflow;

    // Byte operations only see the low byte
    assign width_mask = is_8_bit ? 16'h00ff : 16'hffff;
    assign a_w = a & width_mask;
    assign b_w = b & width_mask;

    assign is_sub = (op == op_sub) || (op == op_sbb);
    assign is_arith = is_sub || (op == op_add) || (op == op_adc);
    assign cin = carry_in & ((op == op_adc) || (op == op_sbb));
    assign cin_ext = {{data_width{1'b0}}, cin};

    // Borrow shows up as ones above the selected width
    assign sum = is_sub ? {1'b0, a_w} - {1'b0, b_w} - cin_ext
                        : {1'b0, a_w} + {1'b0, b_w} + cin_ext;

    always_comb begin
        case (op)
            op_and:  raw = a_w & b_w;
            op_or:   raw = a_w | b_w;
            op_xor:  raw = a_w ^ b_w;
            default: raw = sum[data_width-1:0];
        endcase
    end

    assign alu_result = raw & width_mask;

    assign sign_a = is_8_bit ? a_w[7] : a_w[data_width-1];
    assign sign_b = is_8_bit ? b_w[7] : b_w[data_width-1];
    assign sign_r = is_8_bit ? alu_result[7] : alu_result[data_width-1];
    assign carry = is_8_bit ? sum[8] : sum[data_width];

    always_comb begin
        if (is_sub) begin
            overflow = (sign_a != sign_b) && (sign_r != sign_a);
        end else begin
            overflow = (sign_a == sign_b) && (sign_r != sign_a);
        end
    end

    always_comb begin
        alu_flags = '0;
        alu_flags[cf_idx] = is_arith & carry;
        alu_flags[of_idx] = is_arith & overflow;
        alu_flags[zf_idx] = (alu_result == '0);
        alu_flags[sf_idx] = sign_r;
        // Even parity over the low byte only
        alu_flags[pf_idx] = ~^alu_result[7:0];
    end

endmodule

// ==== exec_divider.sv ====
module exec_divider
    import exec_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    div_start,
    input  alu_op_t op,
    input  logic    is_8_bit,
    input  word_t   a,
    input  word_t   b,
    input  word_t   c,
    output logic    div_done,
    output word_t   quotient,
    output word_t   remainder,
    output logic    div_fault
);

    div_state_t  state;
    logic [4:0]  count;

    // Operand decode ahead of the latch
    logic        start_signed;
    logic        dividend_in_neg;
    logic        divisor_in_neg;
    dword_t      dividend_wide;
    word_t       dividend_short;
    dword_t      dividend_mag;
    word_t       divisor_wide;
    logic [7:0]  divisor_short;
    word_t       divisor_mag;

    // Latched operation
    logic        is_signed_q;
    logic        is_8_bit_q;
    logic        dividend_neg;
    logic        divisor_neg;
    dword_t      quo;
    word_t       rem;
    word_t       divisor;

    logic [17:0] trial;
    logic        quo_neg;
    dword_t      quo_mag;
    dword_t      quo_signed;
    word_t       rem_signed;
    dword_t      half_range;
    logic        overflow;

    assign start_signed = (op == op_idiv);
    assign dividend_in_neg = start_signed & (is_8_bit ? b[15] : a[15]);
    assign divisor_in_neg = start_signed & (is_8_bit ? c[7] : c[15]);

    assign dividend_wide = dividend_in_neg ? -{a, b} : {a, b};
    assign dividend_short = dividend_in_neg ? -b : b;
    assign divisor_wide = divisor_in_neg ? -c : c;
    assign divisor_short = divisor_in_neg ? -c[7:0] : c[7:0];

    // Byte divide starts left aligned so 16 steps consume it
    assign dividend_mag = is_8_bit ? {dividend_short, 16'h0000} : dividend_wide;
    assign divisor_mag = is_8_bit ? {8'h00, divisor_short} : divisor_wide;

    // One restoring step
    assign trial = {1'b0, rem, quo[31]} - {2'b00, divisor};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= div_idle;
            count <= '0;
        end else begin
            case (state)
                div_idle: begin
                    if (div_start) begin
                        count <= is_8_bit ? 5'd15 : 5'd31;
                        state <= (divisor_mag == '0) ? div_fix : div_run;
                    end
                end
                div_run: begin
                    count <= count - 5'd1;
                    if (count == 5'd0) begin
                        state <= div_fix;
                    end
                end
                default: state <= div_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == div_idle && div_start) begin
            is_signed_q <= start_signed;
            is_8_bit_q <= is_8_bit;
            dividend_neg <= dividend_in_neg;
            divisor_neg <= divisor_in_neg;
            quo <= dividend_mag;
            rem <= '0;
            divisor <= divisor_mag;
        end else if (state == div_run) begin
            quo <= {quo[30:0], ~trial[17]};
            if (!trial[17]) begin
                rem <= trial[15:0];
            end else begin
                rem <= {rem[14:0], quo[31]};
            end
        end
    end

    // Signs restored so the quotient truncates toward zero
    assign quo_neg = dividend_neg ^ divisor_neg;
    assign quo_mag = is_8_bit_q ? {16'h0000, quo[15:0]} : quo;
    assign quo_signed = quo_neg ? -quo_mag : quo_mag;
    assign rem_signed = dividend_neg ? -rem : rem;
    assign half_range = is_8_bit_q ? 32'd128 : 32'd32768;

    always_comb begin
        if (is_signed_q) begin
            overflow = quo_mag > (quo_neg ? half_range : half_range - 32'd1);
        end else if (is_8_bit_q) begin
            overflow = (quo_mag[15:8] != 8'h00);
        end else begin
            overflow = (quo_mag[31:16] != 16'h0000);
        end
    end

    assign div_done = (state == div_fix);
    assign div_fault = (divisor == '0) | overflow;
    assign quotient = is_8_bit_q ? {8'h00, quo_signed[7:0]} : quo_signed[15:0];
    assign remainder = is_8_bit_q ? {8'h00, rem_signed[7:0]} : rem_signed;

endmodule

// ==== exec_result_stage.sv ====
module exec_result_stage
    import exec_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start,
    input  alu_op_t op,
    input  word_t   alu_result,
    input  flags_t  alu_flags,
    input  logic    div_done,
    input  word_t   quotient,
    input  word_t   remainder,
    input  logic    div_fault,
    output logic    div_start,
    output logic    carry_out,
    output logic    busy,
    output logic    done,
    output word_t   result,
    output word_t   result_hi,
    output flags_t  flags,
    output logic    div_error
);

    logic is_div_op;
    logic accept;
    logic alu_capture;
    logic div_finish;

    assign is_div_op = (op == op_div) || (op == op_idiv);

    // Strobes during a divide are dropped
    assign accept = start & ~busy;
    assign div_start = accept & is_div_op;
    assign alu_capture = accept & ~is_div_op;
    assign div_finish = busy & div_done;

    // ADC and SBB read back the stored carry
    assign carry_out = flags[cf_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            div_error <= 1'b0;
            result <= '0;
            result_hi <= '0;
            flags <= '0;
        end else begin
            done <= alu_capture | div_finish;
            div_error <= div_finish & div_fault;

            if (div_start) begin
                busy <= 1'b1;
            end else if (div_finish) begin
                busy <= 1'b0;
            end

            if (alu_capture) begin
                result <= alu_result;
                result_hi <= '0;
                flags <= alu_flags;
            end else if (div_finish && !div_fault) begin
                // Flags untouched by a divide
                result <= quotient;
                result_hi <= remainder;
            end
        end
    end

endmodule

// ==== exec_unit.sv ====
module exec_unit
    import exec_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start,
    input  alu_op_t op,
    input  logic    is_8_bit,
    input  word_t   a,
    input  word_t   b,
    input  word_t   c,
    output logic    busy,
    output logic    done,
    output word_t   result,
    output word_t   result_hi,
    output flags_t  flags,
    output logic    div_error
);

    word_t  alu_result;
    flags_t alu_flags;
    logic   carry;
    logic   div_start;
    logic   div_done;
    word_t  quotient;
    word_t  remainder;
    logic   div_fault;

    exec_alu alu0 (
        .op         (op),
        .is_8_bit   (is_8_bit),
        .a          (a),
        .b          (b),
        .carry_in   (carry),
        .alu_result (alu_result),
        .alu_flags  (alu_flags)
    );

    exec_divider div0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .div_start (div_start),
        .op        (op),
        .is_8_bit  (is_8_bit),
        .a         (a),
        .b         (b),
        .c         (c),
        .div_done  (div_done),
        .quotient  (quotient),
        .remainder (remainder),
        .div_fault (div_fault)
    );

    exec_result_stage res0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .op         (op),
        .alu_result (alu_result),
        .alu_flags  (alu_flags),
        .div_done   (div_done),
        .quotient   (quotient),
        .remainder  (remainder),
        .div_fault  (div_fault),
        .div_start  (div_start),
        .carry_out  (carry),
        .busy       (busy),
        .done       (done),
        .result     (result),
        .result_hi  (result_hi),
        .flags      (flags),
        .div_error  (div_error)
    );

endmodule

// ==== exec_unit_chk.sv ====
module exec_unit_chk (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic done,
    input logic div_error
);
    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0;

    // Done is a single cycle pulse
    done_single: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            failures++;
        end

    error_with_done: assert property (@(posedge clk) disable iff (!rst_n) div_error |-> done)
        else begin
            $error("div_error high without done");
            failures++;
        end

    idle_in_reset: assert property (@(posedge clk) !rst_n |-> !busy && !done)
        else begin
            $error("busy or done high during reset");
            failures++;
        end

endmodule

bind exec_unit exec_unit_chk chk0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .busy      (busy),
    .done      (done),
    .div_error (div_error)
);

// ==== tb_exec_unit.sv ====
module tb_exec_unit
    import exec_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period = 40;
    localparam int n_alu = 200;
    localparam int n_chain = 120;
    localparam int n_div = 240;
    localparam int n_ignore = 20;
    localparam int n_ops = n_alu + n_chain + n_div + n_ignore;
    localparam int max_wait = 40;

    logic    clk;
    logic    rst_n;
    logic    start;
    alu_op_t op;
    logic    is_8_bit;
    word_t   a;
    word_t   b;
    word_t   c;
    logic    busy;
    logic    done;
    word_t   result;
    word_t   result_hi;
    flags_t  flags;
    logic    div_error;

    integer  seed;
    int      error_count;
    int      check_count;
    word_t   exp_result;
    word_t   exp_result_hi;
    flags_t  exp_flags;
    logic    exp_error;
    alu_op_t basic_ops [5] = '{op_add, op_sub, op_and, op_or, op_xor};
    alu_op_t chain_ops [6] = '{op_adc, op_sbb, op_adc, op_sbb, op_add, op_sub};

    exec_unit dut0 (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    initial begin
        #((n_ops * max_wait + 16) * clk_period);
        $display("Timeout: the test sequence did not complete in time");
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic word_t rand_word();
        int r;
        r = $random(seed);
        return r[15:0];
    endfunction

    function automatic int rand_below(int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fffffff) % n;
    endfunction

    task automatic compare_value(input string what, input word_t got, input word_t expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("FAIL %0d ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic alu_model(input alu_op_t m_op, input logic m_8, input word_t m_a,
                             input word_t m_b);
        int width;
        int mask;
        int ua;
        int ub;
        int sa;
        int sb;
        int cin;
        int full;
        int sfull;
        width = m_8 ? 8 : 16;
        mask = (1 << width) - 1;
        ua = int'(m_a) & mask;
        ub = int'(m_b) & mask;
        // Two's complement view of the operands
        sa = (ua > mask / 2) ? ua - mask - 1 : ua;
        sb = (ub > mask / 2) ? ub - mask - 1 : ub;
        cin = (m_op == op_adc || m_op == op_sbb) ? int'(exp_flags[cf_idx]) : 0;
        exp_flags = '0;
        case (m_op)
            op_and: full = ua & ub;
            op_or:  full = ua | ub;
            op_xor: full = ua ^ ub;
            op_sub, op_sbb: full = ua - ub - cin;
            default: full = ua + ub + cin;
        endcase
        if (m_op == op_add || m_op == op_adc) begin
            sfull = sa + sb + cin;
            exp_flags[cf_idx] = full > mask;
            exp_flags[of_idx] = (sfull > mask / 2) || (sfull < -(mask / 2) - 1);
        end else if (m_op == op_sub || m_op == op_sbb) begin
            sfull = sa - sb - cin;
            exp_flags[cf_idx] = full < 0;
            exp_flags[of_idx] = (sfull > mask / 2) || (sfull < -(mask / 2) - 1);
        end
        exp_result = word_t'(full & mask);
        exp_flags[zf_idx] = (exp_result == '0);
        exp_flags[sf_idx] = full[width-1];
        exp_flags[pf_idx] = ~^exp_result[7:0];
        exp_result_hi = '0;
        exp_error = 1'b0;
    endtask

    task automatic div_model(input alu_op_t m_op, input logic m_8, input word_t m_a,
                             input word_t m_b, input word_t m_c);
        longint dividend;
        longint divisor;
        longint q;
        longint lo;
        longint hi;
        longint mask;
        mask = m_8 ? 255 : 65535;
        if (m_op == op_idiv) begin
            dividend = m_8 ? longint'($signed(m_b)) : longint'($signed({m_a, m_b}));
            divisor = m_8 ? longint'($signed(m_c[7:0])) : longint'($signed(m_c));
            hi = m_8 ? 127 : 32767;
            lo = -hi - 1;
        end else begin
            dividend = m_8 ? longint'(m_b) : longint'({m_a, m_b});
            divisor = m_8 ? longint'(m_c[7:0]) : longint'(m_c);
            hi = mask;
            lo = 0;
        end
        // Failed divides keep the previous outputs
        exp_error = 1'b1;
        if (divisor != 0) begin
            q = dividend / divisor;
            if (q >= lo && q <= hi) begin
                exp_error = 1'b0;
                exp_result = word_t'(q & mask);
                exp_result_hi = word_t'((dividend % divisor) & mask);
            end
        end
    endtask

    task automatic run_op(input alu_op_t t_op, input logic t_8, input word_t t_a,
                          input word_t t_b, input word_t t_c, input bit inject);
        int waited;
        bit is_div;
        is_div = (t_op == op_div) || (t_op == op_idiv);
        if (is_div) begin
            div_model(t_op, t_8, t_a, t_b, t_c);
        end else begin
            alu_model(t_op, t_8, t_a, t_b);
        end
        @(posedge clk);
        #2;
        start = 1'b1;
        op = t_op;
        is_8_bit = t_8;
        a = t_a;
        b = t_b;
        c = t_c;
        @(posedge clk);
        #2;
        start = 1'b0;
        a = rand_word();
        b = rand_word();
        c = rand_word();
        @(negedge clk);
        waited = 0;
        while (!done && waited < max_wait) begin
            if (is_div) begin
                compare_value("busy during divide", word_t'(busy), 16'h0001);
            end
            @(posedge clk);
            #2;
            // ALU strobe in the middle of a divide
            start = inject && (waited == 2);
            op = start ? op_add : t_op;
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            error_count++;
            $display("Error: no done within %0d cycles of a start", max_wait);
        end else begin
            if (!is_div) begin
                compare_value("ALU latency", word_t'(waited), '0);
            end
            compare_value("busy at done", word_t'(busy), '0);
            compare_value("div_error", word_t'(div_error), word_t'(exp_error));
            compare_value("result", result, exp_result);
            compare_value("result_hi", result_hi, exp_result_hi);
            compare_value("flags", flags, exp_flags);
        end
        if (inject) begin
            repeat (3) begin
                @(negedge clk);
                compare_value("done after ignored start", word_t'(done), '0);
            end
            compare_value("result after ignored start", result, exp_result);
        end
    endtask

    task automatic issue_divide(input bit inject);
        alu_op_t d_op;
        logic    d_8;
        word_t   d_a;
        word_t   d_b;
        word_t   d_c;
        int      shape;
        d_op = (rand_below(2) == 1) ? op_idiv : op_div;
        d_8 = rand_below(2) == 1;
        d_a = rand_word();
        d_b = rand_word();
        d_c = rand_word();
        shape = rand_below(8);
        if (shape == 0) begin
            d_c = '0;
        end else if (shape >= 3) begin
            // Dividend narrowed so the quotient usually fits
            if (d_8) begin
                d_b = {{8{d_b[7] & (d_op == op_idiv)}}, d_b[7:0]};
            end else begin
                d_a = {16{d_b[15] & (d_op == op_idiv)}};
            end
        end
        if (inject) begin
            d_c[0] = 1'b1;
        end
        run_op(d_op, d_8, d_a, d_b, d_c, inject);
    endtask

    initial begin
        seed = 32'hd7ed;
        error_count = 0;
        check_count = 0;
        rst_n = 1'b0;
        start = 1'b0;
        op = op_add;
        is_8_bit = 1'b0;
        a = '0;
        b = '0;
        c = '0;
        exp_result = '0;
        exp_result_hi = '0;
        exp_flags = '0;
        exp_error = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        compare_value("result after reset", result, '0);
        compare_value("result_hi after reset", result_hi, '0);
        compare_value("flags after reset", flags, '0);
        compare_value("busy after reset", word_t'(busy), '0);
        for (int i = 0; i < n_alu; i++) begin
            run_op(basic_ops[rand_below(5)], rand_below(2) == 1, rand_word(), rand_word(),
                   rand_word(), 1'b0);
        end
        for (int i = 0; i < n_chain; i++) begin
            run_op(chain_ops[rand_below(6)], rand_below(2) == 1, rand_word(), rand_word(),
                   rand_word(), 1'b0);
        end
        for (int i = 0; i < n_div; i++) begin
            issue_divide(1'b0);
        end
        for (int i = 0; i < n_ignore; i++) begin
            issue_divide(1'b1);
        end
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, dut0.chk0.failures);
        if (error_count == 0 && dut0.chk0.failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
exec_pkg.sv
exec_alu.sv
exec_divider.sv
exec_result_stage.sv
exec_unit.sv
exec_unit_chk.sv
tb_exec_unit.sv

// ==== run.sh ====
#!/bin/sh
set -e

verilator --binary --timing --assert -f flist.f --top-module tb_exec_unit -o sim_exec_unit

out=$(./obj_dir/sim_exec_unit)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'STATUS: PASS'; then
    exit 0
fi
exit 1
